/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_csr
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "Everything OK" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/csr_cfg.svh */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// word and address widths
`define CSR_DATA_W 32
`define CSR_ADDR_W 14
`define CNT_W 64
`define EXCP_W 8
`define HWI_W 8
`define INT_W 13
`define ECODE_W 6
`define ESUBCODE_W 9

// crmd and prmd fields
`define CRMD_PLV 1:0
`define CRMD_IE 2
`define CRMD_DA 3
`define PRMD_PPLV 1:0
`define PRMD_PIE 2

// estat fields
`define ESTAT_IS (`INT_W-1):0
`define ESTAT_SWI 1:0
`define ESTAT_HWI 9:2
`define ESTAT_TI 11
`define ESTAT_ECODE 21:16
`define ESTAT_ESUBCODE 30:22

// bit 10 of the local enables is reserved
`define ECTL_LIE (`INT_W-1):0
`define ECTL_LIE_MSK 13'h1bff

// timer fields
`define TCFG_EN 0
`define TCFG_PERIODIC 1
`define TCFG_INITVAL 31:2
`define TICLR_CLR 0

`define EENTRY_VA_LSB 6

// direct address mode after reset
`define CRMD_RST 32'h0000_0008

`endif

/* common/csr_pkg.sv */
`include "csr_cfg.svh"

package csr_pkg;

  // architectural csr numbers
  typedef enum logic [`CSR_ADDR_W-1:0] {
    csr_crmd   = 14'h000,
    csr_prmd   = 14'h001,
    csr_ectl   = 14'h004,
    csr_estat  = 14'h005,
    csr_era    = 14'h006,
    csr_badv   = 14'h007,
    csr_eentry = 14'h00c,
    csr_save0  = 14'h030,
    csr_save1  = 14'h031,
    csr_save2  = 14'h032,
    csr_save3  = 14'h033,
    csr_tid    = 14'h040,
    csr_tcfg   = 14'h041,
    csr_tval   = 14'h042,
    csr_ticlr  = 14'h044
  } csr_addr_e;

  typedef enum logic [1:0] {
    rdcnt_csr  = 2'd0,
    rdcnt_id   = 2'd1,
    rdcnt_low  = 2'd2,
    rdcnt_high = 2'd3
  } rdcnt_e;

  typedef enum logic [`ECODE_W-1:0] {
    ecode_int = 6'h00,
    ecode_ade = 6'h08,
    ecode_ale = 6'h09,
    ecode_sys = 6'h0b,
    ecode_brk = 6'h0c,
    ecode_ine = 6'h0d,
    ecode_ipe = 6'h0e
  } ecode_e;

  // highest priority first
  typedef enum logic [$clog2(`EXCP_W)-1:0] {
    excp_int, excp_adef, excp_adem, excp_ale,
    excp_sys, excp_brk, excp_ine, excp_ipe
  } excp_idx_e;

endpackage

/* excp/excp_priority.sv */
`include "csr_cfg.svh"

module excp_priority (
  input  logic [`EXCP_W-1:0]     excp_flags_i,
  output logic                   excp_valid_o,
  output csr_pkg::ecode_e        ecode_o,
  output logic [`ESUBCODE_W-1:0] esubcode_o,
  output logic                   badv_is_pc_o,
  output logic                   va_error_o
);

  logic addr_err;

  assign excp_valid_o = |excp_flags_i;

  always_comb begin
    ecode_o    = csr_pkg::ecode_int;
    esubcode_o = '0;
    if (excp_flags_i[csr_pkg::excp_int]) begin
      ecode_o = csr_pkg::ecode_int;
    end else if (excp_flags_i[csr_pkg::excp_adef]) begin
      ecode_o = csr_pkg::ecode_ade;
    end else if (excp_flags_i[csr_pkg::excp_adem]) begin
      // same code as adef, told apart by esubcode
      ecode_o    = csr_pkg::ecode_ade;
      esubcode_o = `ESUBCODE_W'd1;
    end else if (excp_flags_i[csr_pkg::excp_ale]) begin
      ecode_o = csr_pkg::ecode_ale;
    end else if (excp_flags_i[csr_pkg::excp_sys]) begin
      ecode_o = csr_pkg::ecode_sys;
    end else if (excp_flags_i[csr_pkg::excp_brk]) begin
      ecode_o = csr_pkg::ecode_brk;
    end else if (excp_flags_i[csr_pkg::excp_ine]) begin
      ecode_o = csr_pkg::ecode_ine;
    end else if (excp_flags_i[csr_pkg::excp_ipe]) begin
      ecode_o = csr_pkg::ecode_ipe;
    end
  end

  // only when an address error is the recorded cause
  assign addr_err = excp_flags_i[csr_pkg::excp_adef] |
                    excp_flags_i[csr_pkg::excp_adem] |
                    excp_flags_i[csr_pkg::excp_ale];

  assign va_error_o   = addr_err & ~excp_flags_i[csr_pkg::excp_int];
  assign badv_is_pc_o = excp_flags_i[csr_pkg::excp_adef] & ~excp_flags_i[csr_pkg::excp_int];

endmodule

/* excp/excp_state.sv */
`include "csr_cfg.svh"

module excp_state (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   excp_valid_i,
  input  csr_pkg::ecode_e        ecode_i,
  input  logic [`ESUBCODE_W-1:0] esubcode_i,
  input  logic                   badv_is_pc_i,
  input  logic                   va_error_i,
  input  logic                   ertn_i,
  input  logic [`CSR_DATA_W-1:0] pc_i,
  input  logic [`CSR_DATA_W-1:0] vaddr_i,
  input  logic [`HWI_W-1:0]      hw_int_i,
  input  logic                   timer_fire_i,
  input  logic                   ticlr_clr_i,
  input  logic [`CSR_DATA_W-1:0] w_data_i,
  input  logic                   crmd_we_i,
  input  logic                   prmd_we_i,
  input  logic                   ectl_we_i,
  input  logic                   estat_we_i,
  input  logic                   era_we_i,
  input  logic                   badv_we_i,
  input  logic                   eentry_we_i,
  output logic [`CSR_DATA_W-1:0] crmd_o,
  output logic [`CSR_DATA_W-1:0] prmd_o,
  output logic [`CSR_DATA_W-1:0] ectl_o,
  output logic [`CSR_DATA_W-1:0] estat_o,
  output logic [`CSR_DATA_W-1:0] era_o,
  output logic [`CSR_DATA_W-1:0] badv_o,
  output logic [`CSR_DATA_W-1:0] eentry_o,
  output logic                   int_o
);

  logic [`CSR_DATA_W-1:0]              crmd_q;
  logic [`CSR_DATA_W-1:0]              prmd_q;
  logic [`CSR_DATA_W-1:0]              ectl_q;
  logic [`CSR_DATA_W-1:0]              estat_q;
  logic [`CSR_DATA_W-1:0]              era_q;
  logic [`CSR_DATA_W-1:0]              badv_q;
  logic [`CSR_DATA_W-1:`EENTRY_VA_LSB] eentry_va_q;
  logic [`INT_W-1:0]                   int_pend;

  // later assignments win, so software writes override hardware updates
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q  <= `CRMD_RST;
      prmd_q  <= '0;
      ectl_q  <= '0;
      estat_q <= '0;
      era_q   <= '0;
    end else begin
      estat_q[`ESTAT_HWI] <= hw_int_i;
      if (timer_fire_i) begin
        estat_q[`ESTAT_TI] <= 1'b1;
      end
      if (ticlr_clr_i) begin
        estat_q[`ESTAT_TI] <= 1'b0;
      end
      if (excp_valid_i) begin
        prmd_q[`PRMD_PPLV]        <= crmd_q[`CRMD_PLV];
        prmd_q[`PRMD_PIE]         <= crmd_q[`CRMD_IE];
        crmd_q[`CRMD_PLV]         <= 2'b00;
        crmd_q[`CRMD_IE]          <= 1'b0;
        estat_q[`ESTAT_ECODE]     <= ecode_i;
        estat_q[`ESTAT_ESUBCODE]  <= esubcode_i;
        era_q                     <= pc_i;
      end
      if (ertn_i) begin
        crmd_q[`CRMD_PLV] <= prmd_q[`PRMD_PPLV];
        crmd_q[`CRMD_IE]  <= prmd_q[`PRMD_PIE];
      end
      if (crmd_we_i) begin
        crmd_q[`CRMD_PLV] <= w_data_i[`CRMD_PLV];
        crmd_q[`CRMD_IE]  <= w_data_i[`CRMD_IE];
        crmd_q[`CRMD_DA]  <= w_data_i[`CRMD_DA];
      end
      if (prmd_we_i) begin
        prmd_q[`PRMD_PPLV] <= w_data_i[`PRMD_PPLV];
        prmd_q[`PRMD_PIE]  <= w_data_i[`PRMD_PIE];
      end
      if (ectl_we_i) begin
        ectl_q[`ECTL_LIE] <= w_data_i[`ECTL_LIE] & `ECTL_LIE_MSK;
      end
      // only the software interrupt bits are writable
      if (estat_we_i) begin
        estat_q[`ESTAT_SWI] <= w_data_i[`ESTAT_SWI];
      end
      if (era_we_i) begin
        era_q <= w_data_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (va_error_i) begin
      badv_q <= badv_is_pc_i ? pc_i : vaddr_i;
    end
    if (badv_we_i) begin
      badv_q <= w_data_i;
    end
    if (eentry_we_i) begin
      eentry_va_q <= w_data_i[`CSR_DATA_W-1:`EENTRY_VA_LSB];
    end
  end

  assign int_pend = estat_q[`ESTAT_IS] & ectl_q[`ECTL_LIE];
  assign int_o    = (|int_pend) & crmd_q[`CRMD_IE];

  assign crmd_o   = crmd_q;
  assign prmd_o   = prmd_q;
  assign ectl_o   = ectl_q;
  assign estat_o  = estat_q;
  assign era_o    = era_q;
  assign badv_o   = badv_q;
  assign eentry_o = {eentry_va_q, {`EENTRY_VA_LSB{1'b0}}};

  // the pipeline never retires an ertn that also raised an exception
  a_excp_ertn_excl: assert property (
    @(posedge clk) disable iff (!rst_n) !(excp_valid_i && ertn_i)
  );

endmodule

/* logic/csr_access.sv */
`include "csr_cfg.svh"

module csr_access (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall_i,
  input  logic                   csr_we_i,
  input  logic [`CSR_ADDR_W-1:0] csr_w_addr_i,
  input  logic [`CSR_DATA_W-1:0] csr_w_mask_i,
  input  logic [`CSR_DATA_W-1:0] csr_w_data_i,
  input  logic [`CSR_ADDR_W-1:0] csr_r_addr_i,
  input  csr_pkg::rdcnt_e        rdcnt_i,
  input  logic [`CSR_DATA_W-1:0] crmd_i,
  input  logic [`CSR_DATA_W-1:0] prmd_i,
  input  logic [`CSR_DATA_W-1:0] ectl_i,
  input  logic [`CSR_DATA_W-1:0] estat_i,
  input  logic [`CSR_DATA_W-1:0] era_i,
  input  logic [`CSR_DATA_W-1:0] badv_i,
  input  logic [`CSR_DATA_W-1:0] eentry_i,
  input  logic [`CSR_DATA_W-1:0] tcfg_i,
  input  logic [`CSR_DATA_W-1:0] tval_i,
  input  logic [`CSR_DATA_W-1:0] tid_i,
  input  logic [`CNT_W-1:0]      cnt_i,
  output logic [`CSR_DATA_W-1:0] w_data_o,
  output logic                   crmd_we_o,
  output logic                   prmd_we_o,
  output logic                   ectl_we_o,
  output logic                   estat_we_o,
  output logic                   era_we_o,
  output logic                   badv_we_o,
  output logic                   eentry_we_o,
  output logic                   tcfg_we_o,
  output logic                   tid_we_o,
  output logic                   ticlr_clr_o,
  output logic [`CSR_DATA_W-1:0] csr_r_data_o
);

  logic                   we;
  logic                   ticlr_we;
  logic [3:0]             save_we;
  logic [`CSR_DATA_W-1:0] save_q [4];
  logic [`CSR_DATA_W-1:0] r_data;

  assign we = csr_we_i && !stall_i;

  // merge against the value read in the previous cycle
  assign w_data_o = (csr_r_data_o & ~csr_w_mask_i) | (csr_w_data_i & csr_w_mask_i);

  always_comb begin
    crmd_we_o   = 1'b0;
    prmd_we_o   = 1'b0;
    ectl_we_o   = 1'b0;
    estat_we_o  = 1'b0;
    era_we_o    = 1'b0;
    badv_we_o   = 1'b0;
    eentry_we_o = 1'b0;
    tcfg_we_o   = 1'b0;
    tid_we_o    = 1'b0;
    ticlr_we    = 1'b0;
    save_we     = '0;
    case (csr_w_addr_i)
      csr_pkg::csr_crmd:   crmd_we_o   = we;
      csr_pkg::csr_prmd:   prmd_we_o   = we;
      csr_pkg::csr_ectl:   ectl_we_o   = we;
      csr_pkg::csr_estat:  estat_we_o  = we;
      csr_pkg::csr_era:    era_we_o    = we;
      csr_pkg::csr_badv:   badv_we_o   = we;
      csr_pkg::csr_eentry: eentry_we_o = we;
      csr_pkg::csr_save0:  save_we[0]  = we;
      csr_pkg::csr_save1:  save_we[1]  = we;
      csr_pkg::csr_save2:  save_we[2]  = we;
      csr_pkg::csr_save3:  save_we[3]  = we;
      csr_pkg::csr_tid:    tid_we_o    = we;
      csr_pkg::csr_tcfg:   tcfg_we_o   = we;
      csr_pkg::csr_ticlr:  ticlr_we    = we;
      default: ;
    endcase
  end

  assign ticlr_clr_o = ticlr_we && w_data_o[`TICLR_CLR];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 4; i++) begin
        save_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (save_we[i]) begin
          save_q[i] <= w_data_o;
        end
      end
    end
  end

  // ticlr, tval and unknown numbers fall through here where needed
  always_comb begin
    r_data = '0;
    case (rdcnt_i)
      csr_pkg::rdcnt_id:   r_data = tid_i;
      csr_pkg::rdcnt_low:  r_data = cnt_i[`CSR_DATA_W-1:0];
      csr_pkg::rdcnt_high: r_data = cnt_i[`CNT_W-1:`CSR_DATA_W];
      default: begin
        case (csr_r_addr_i)
          csr_pkg::csr_crmd:   r_data = crmd_i;
          csr_pkg::csr_prmd:   r_data = prmd_i;
          csr_pkg::csr_ectl:   r_data = ectl_i;
          csr_pkg::csr_estat:  r_data = estat_i;
          csr_pkg::csr_era:    r_data = era_i;
          csr_pkg::csr_badv:   r_data = badv_i;
          csr_pkg::csr_eentry: r_data = eentry_i;
          csr_pkg::csr_save0:  r_data = save_q[0];
          csr_pkg::csr_save1:  r_data = save_q[1];
          csr_pkg::csr_save2:  r_data = save_q[2];
          csr_pkg::csr_save3:  r_data = save_q[3];
          csr_pkg::csr_tid:    r_data = tid_i;
          csr_pkg::csr_tcfg:   r_data = tcfg_i;
          csr_pkg::csr_tval:   r_data = tval_i;
          default:             r_data = '0;
        endcase
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      csr_r_data_o <= '0;
    end else if (!stall_i) begin
      csr_r_data_o <= r_data;
    end
  end

endmodule

/* logic/csr_top.sv */
`include "csr_cfg.svh"

module csr_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall_i,
  input  logic                   csr_we_i,
  input  logic [`CSR_ADDR_W-1:0] csr_w_addr_i,
  input  logic [`CSR_DATA_W-1:0] csr_w_mask_i,
  input  logic [`CSR_DATA_W-1:0] csr_w_data_i,
  input  logic [`CSR_ADDR_W-1:0] csr_r_addr_i,
  input  csr_pkg::rdcnt_e        rdcnt_i,
  input  logic [`EXCP_W-1:0]     excp_flags_i,
  input  logic                   ertn_i,
  input  logic [`CSR_DATA_W-1:0] pc_i,
  input  logic [`CSR_DATA_W-1:0] vaddr_i,
  input  logic [`HWI_W-1:0]      hw_int_i,
  output logic [`CSR_DATA_W-1:0] csr_r_data_o,
  output logic                   int_o
);

  logic [`CSR_DATA_W-1:0]  w_data;
  logic                    crmd_we, prmd_we, ectl_we, estat_we;
  logic                    era_we, badv_we, eentry_we, tcfg_we, tid_we;
  logic                    ticlr_clr;
  logic [`CSR_DATA_W-1:0]  crmd, prmd, ectl, estat, era, badv, eentry;
  logic [`CSR_DATA_W-1:0]  tcfg, tval, tid;
  logic [`CNT_W-1:0]       cnt;
  logic                    timer_fire;
  logic                    excp_valid;
  csr_pkg::ecode_e         ecode;
  logic [`ESUBCODE_W-1:0]  esubcode;
  logic                    badv_is_pc;
  logic                    va_error;

  csr_access i_access (
    .clk, .rst_n, .stall_i, .csr_we_i, .csr_w_addr_i, .csr_w_mask_i, .csr_w_data_i,
    .csr_r_addr_i, .rdcnt_i,
    .crmd_i(crmd), .prmd_i(prmd), .ectl_i(ectl), .estat_i(estat), .era_i(era),
    .badv_i(badv), .eentry_i(eentry), .tcfg_i(tcfg), .tval_i(tval), .tid_i(tid),
    .cnt_i(cnt), .w_data_o(w_data),
    .crmd_we_o(crmd_we), .prmd_we_o(prmd_we), .ectl_we_o(ectl_we),
    .estat_we_o(estat_we), .era_we_o(era_we), .badv_we_o(badv_we),
    .eentry_we_o(eentry_we), .tcfg_we_o(tcfg_we), .tid_we_o(tid_we),
    .ticlr_clr_o(ticlr_clr), .csr_r_data_o
  );

  excp_priority i_priority (
    .excp_flags_i, .excp_valid_o(excp_valid), .ecode_o(ecode),
    .esubcode_o(esubcode), .badv_is_pc_o(badv_is_pc), .va_error_o(va_error)
  );

  excp_state i_state (
    .clk, .rst_n, .excp_valid_i(excp_valid), .ecode_i(ecode), .esubcode_i(esubcode),
    .badv_is_pc_i(badv_is_pc), .va_error_i(va_error), .ertn_i, .pc_i, .vaddr_i,
    .hw_int_i, .timer_fire_i(timer_fire), .ticlr_clr_i(ticlr_clr), .w_data_i(w_data),
    .crmd_we_i(crmd_we), .prmd_we_i(prmd_we), .ectl_we_i(ectl_we),
    .estat_we_i(estat_we), .era_we_i(era_we), .badv_we_i(badv_we),
    .eentry_we_i(eentry_we),
    .crmd_o(crmd), .prmd_o(prmd), .ectl_o(ectl), .estat_o(estat), .era_o(era),
    .badv_o(badv), .eentry_o(eentry), .int_o
  );

  timer_unit i_timer (
    .clk, .rst_n, .w_data_i(w_data), .tcfg_we_i(tcfg_we), .tid_we_i(tid_we),
    .tcfg_o(tcfg), .tval_o(tval), .tid_o(tid), .cnt_o(cnt), .timer_fire_o(timer_fire)
  );

endmodule

/* testbench/tb_csr_tasks.svh */
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

task automatic test_reset_values();
  expect_csr(csr_pkg::csr_crmd, `CRMD_RST, "crmd reset");
  expect_csr(csr_pkg::csr_prmd, '0, "prmd reset");
  expect_csr(csr_pkg::csr_estat, '0, "estat reset");
  expect_csr(csr_pkg::csr_era, '0, "era reset");
  expect_csr(csr_pkg::csr_save0, '0, "save0 reset");
  expect_csr(csr_pkg::csr_tcfg, '0, "tcfg reset");
endtask

task automatic test_masked_write();
  logic [`CSR_DATA_W-1:0] old_v;
  logic [`CSR_DATA_W-1:0] rd_v;
  logic [`CSR_DATA_W-1:0] d;
  logic [`CSR_DATA_W-1:0] m;
  logic [`CSR_DATA_W-1:0] exp_v;
  old_v = $random(seed);
  d     = $random(seed);
  m     = $random(seed);
  write_csr(csr_pkg::csr_save1, old_v, '1);
  read_csr(csr_pkg::csr_save1, rd_v);
  check("save1 full write", rd_v, old_v);
  // merge uses the read from the cycle before
  write_csr(csr_pkg::csr_save1, d, m);
  for (int i = 0; i < `CSR_DATA_W; i++) begin
    exp_v[i] = m[i] ? d[i] : old_v[i];
  end
  expect_csr(csr_pkg::csr_save1, exp_v, "save1 masked write");
  stall = 1'b1;
  write_csr(csr_pkg::csr_save1, ~exp_v, '1);
  stall = 1'b0;
  expect_csr(csr_pkg::csr_save1, exp_v, "save1 write under stall");
endtask

task automatic test_exception();
  logic [`CSR_DATA_W-1:0] v;
  logic [`CSR_DATA_W-1:0] pc_v;
  logic [`CSR_DATA_W-1:0] va_v;
  write_csr(csr_pkg::csr_crmd, 32'h7, '1);
  pc_v = $random(seed);
  va_v = $random(seed);
  pulse_excp(8'b1 << csr_pkg::excp_ale, pc_v, va_v);
  read_csr(csr_pkg::csr_estat, v);
  check("ale ecode", v[`ESTAT_ECODE], CODE_ALE);
  expect_csr(csr_pkg::csr_era, pc_v, "era after ale");
  expect_csr(csr_pkg::csr_badv, va_v, "badv after ale");
  read_csr(csr_pkg::csr_prmd, v);
  check("prmd pplv", v[`PRMD_PPLV], 2'd3);
  check("prmd pie", v[`PRMD_PIE], 1'b1);
  read_csr(csr_pkg::csr_crmd, v);
  check("crmd plv cleared", v[`CRMD_PLV], 2'd0);
  check("crmd ie cleared", v[`CRMD_IE], 1'b0);
  pulse_ertn();
  read_csr(csr_pkg::csr_crmd, v);
  check("crmd plv restored", v[`CRMD_PLV], 2'd3);
  check("crmd ie restored", v[`CRMD_IE], 1'b1);
  pulse_excp(8'b1 << csr_pkg::excp_adem, $random(seed), $random(seed));
  read_csr(csr_pkg::csr_estat, v);
  check("adem ecode", v[`ESTAT_ECODE], CODE_ADE);
  check("adem esubcode", v[`ESTAT_ESUBCODE], 9'd1);
  pc_v = $random(seed);
  // adef outranks ale and sys and puts the pc into badv
  pulse_excp((8'b1 << csr_pkg::excp_adef) | (8'b1 << csr_pkg::excp_ale) |
             (8'b1 << csr_pkg::excp_sys), pc_v, $random(seed));
  read_csr(csr_pkg::csr_estat, v);
  check("adef ecode", v[`ESTAT_ECODE], CODE_ADE);
  check("adef esubcode", v[`ESTAT_ESUBCODE], 9'd0);
  expect_csr(csr_pkg::csr_badv, pc_v, "badv after adef");
  pulse_excp((8'b1 << csr_pkg::excp_sys) | (8'b1 << csr_pkg::excp_brk) |
             (8'b1 << csr_pkg::excp_ipe), $random(seed), $random(seed));
  read_csr(csr_pkg::csr_estat, v);
  check("sys over brk and ipe", v[`ESTAT_ECODE], CODE_SYS);
endtask

task automatic test_timer();
  logic [`CSR_DATA_W-1:0] v;
  write_csr(csr_pkg::csr_ectl, 32'h1 << `ESTAT_TI, '1);
  write_csr(csr_pkg::csr_crmd, 32'h1 << `CRMD_IE, '1);
  // one-shot with initval 3
  write_csr(csr_pkg::csr_tcfg, (32'd3 << 2) | 32'h1, '1);
  wait_int(1'b1);
  read_csr(csr_pkg::csr_estat, v);
  check("estat timer bit", v[`ESTAT_TI], 1'b1);
  write_csr(csr_pkg::csr_ticlr, 32'h1, '1);
  check("int_o after ticlr", int_out, 1'b0);
  // periodic with initval 4
  write_csr(csr_pkg::csr_tcfg, (32'd4 << 2) | 32'h3, '1);
  wait_int(1'b1);
  write_csr(csr_pkg::csr_ticlr, 32'h1, '1);
  check("int_o after first periodic clear", int_out, 1'b0);
  wait_int(1'b1);
  write_csr(csr_pkg::csr_tcfg, 32'h0, '1);
  write_csr(csr_pkg::csr_ticlr, 32'h1, '1);
  check("int_o with timer off", int_out, 1'b0);
  write_csr(csr_pkg::csr_ectl, 32'h0, '1);
endtask

task automatic test_interrupts();
  logic [`CSR_DATA_W-1:0] v;
  int                     idx;
  idx = {$random(seed)} % `HWI_W;
  hw_int[idx] = 1'b1;
  @(negedge clk);
  read_csr(csr_pkg::csr_estat, v);
  // hardware lines sit at estat bits 9:2
  check("estat hw bit", v[2 + idx], 1'b1);
  check("int_o with hw masked", int_out, 1'b0);
  write_csr(csr_pkg::csr_ectl, 32'h1 << (2 + idx), '1);
  check("int_o with hw enabled", int_out, 1'b1);
  write_csr(csr_pkg::csr_ectl, 32'h0, '1);
  check("int_o after hw mask", int_out, 1'b0);
  hw_int = '0;
  write_csr(csr_pkg::csr_estat, 32'h2, '1);
  write_csr(csr_pkg::csr_ectl, 32'h2, '1);
  check("int_o from software bit", int_out, 1'b1);
  write_csr(csr_pkg::csr_estat, 32'h0, '1);
  check("int_o after software clear", int_out, 1'b0);
  write_csr(csr_pkg::csr_ectl, 32'h0, '1);
endtask

task automatic test_counters();
  logic [`CSR_DATA_W-1:0] c0;
  logic [`CSR_DATA_W-1:0] c1;
  logic [`CSR_DATA_W-1:0] t;
  read_cnt(csr_pkg::rdcnt_low, c0);
  read_cnt(csr_pkg::rdcnt_low, c1);
  check("low counter increases", c1 > c0, 1'b1);
  read_cnt(csr_pkg::rdcnt_high, c1);
  check("high counter half", c1, '0);
  t = $random(seed);
  write_csr(csr_pkg::csr_tid, t, '1);
  read_cnt(csr_pkg::rdcnt_id, c1);
  check("counter id", c1, t);
endtask

`endif

/* testbench/tb_csr.sv */
`include "csr_cfg.svh"

module tb_csr;

  localparam int TIMEOUT = 500;

  // architectural exception codes
  localparam logic [5:0] CODE_ADE = 6'h08;
  localparam logic [5:0] CODE_ALE = 6'h09;
  localparam logic [5:0] CODE_SYS = 6'h0b;

  logic                   clk;
  logic                   rst_n;
  logic                   stall;
  logic                   csr_we;
  logic [`CSR_ADDR_W-1:0] csr_w_addr;
  logic [`CSR_DATA_W-1:0] csr_w_mask;
  logic [`CSR_DATA_W-1:0] csr_w_data;
  logic [`CSR_ADDR_W-1:0] csr_r_addr;
  csr_pkg::rdcnt_e        rdcnt;
  logic [`EXCP_W-1:0]     excp_flags;
  logic                   ertn;
  logic [`CSR_DATA_W-1:0] pc;
  logic [`CSR_DATA_W-1:0] vaddr;
  logic [`HWI_W-1:0]      hw_int;
  logic [`CSR_DATA_W-1:0] csr_r_data;
  logic                   int_out;
  integer                 seed;

  csr_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_i      (stall),
    .csr_we_i     (csr_we),
    .csr_w_addr_i (csr_w_addr),
    .csr_w_mask_i (csr_w_mask),
    .csr_w_data_i (csr_w_data),
    .csr_r_addr_i (csr_r_addr),
    .rdcnt_i      (rdcnt),
    .excp_flags_i (excp_flags),
    .ertn_i       (ertn),
    .pc_i         (pc),
    .vaddr_i      (vaddr),
    .hw_int_i     (hw_int),
    .csr_r_data_o (csr_r_data),
    .int_o        (int_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check(input string msg, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED at time %0t: %s, got %h, expected %h", $time, msg, got, exp);
      $display("Something failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // all helpers start and end on a falling edge
  task automatic read_csr(input logic [`CSR_ADDR_W-1:0] addr,
                          output logic [`CSR_DATA_W-1:0] val);
    csr_r_addr = addr;
    rdcnt      = csr_pkg::rdcnt_csr;
    @(posedge clk);
    @(negedge clk);
    val = csr_r_data;
  endtask

  task automatic read_cnt(input csr_pkg::rdcnt_e sel, output logic [`CSR_DATA_W-1:0] val);
    rdcnt = sel;
    @(posedge clk);
    @(negedge clk);
    val   = csr_r_data;
    rdcnt = csr_pkg::rdcnt_csr;
  endtask

  task automatic expect_csr(input logic [`CSR_ADDR_W-1:0] addr,
                            input logic [`CSR_DATA_W-1:0] exp, input string msg);
    logic [`CSR_DATA_W-1:0] v;
    read_csr(addr, v);
    check(msg, v, exp);
  endtask

  task automatic write_csr(input logic [`CSR_ADDR_W-1:0] addr,
                           input logic [`CSR_DATA_W-1:0] data,
                           input logic [`CSR_DATA_W-1:0] mask);
    csr_we     = 1'b1;
    csr_w_addr = addr;
    csr_w_data = data;
    csr_w_mask = mask;
    @(posedge clk);
    @(negedge clk);
    csr_we = 1'b0;
  endtask

  task automatic pulse_excp(input logic [`EXCP_W-1:0] flags,
                            input logic [`CSR_DATA_W-1:0] pc_val,
                            input logic [`CSR_DATA_W-1:0] va_val);
    excp_flags = flags;
    pc         = pc_val;
    vaddr      = va_val;
    @(posedge clk);
    @(negedge clk);
    excp_flags = '0;
  endtask

  task automatic pulse_ertn();
    ertn = 1'b1;
    @(posedge clk);
    @(negedge clk);
    ertn = 1'b0;
  endtask

  task automatic wait_int(input logic level);
    int n;
    n = 0;
    while (int_out !== level && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (int_out !== level) begin
      $display("timeout while waiting for int_o to become %b", level);
      $display("Something failed");
      $fatal(1, "timeout");
    end
  endtask

  `include "tb_csr_tasks.svh"

  initial begin
    seed       = 32'hfea8_bb8d;
    rst_n      = 1'b0;
    stall      = 1'b0;
    csr_we     = 1'b0;
    csr_w_addr = '0;
    csr_w_mask = '0;
    csr_w_data = '0;
    csr_r_addr = '0;
    rdcnt      = csr_pkg::rdcnt_csr;
    excp_flags = '0;
    ertn       = 1'b0;
    pc         = '0;
    vaddr      = '0;
    hw_int     = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_values();
    test_masked_write();
    test_exception();
    test_timer();
    test_interrupts();
    test_counters();
    $display("Everything OK");
    $finish;
  end

endmodule

/* timer/timer_unit.sv */
`include "csr_cfg.svh"

module timer_unit (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`CSR_DATA_W-1:0] w_data_i,
  input  logic                   tcfg_we_i,
  input  logic                   tid_we_i,
  output logic [`CSR_DATA_W-1:0] tcfg_o,
  output logic [`CSR_DATA_W-1:0] tval_o,
  output logic [`CSR_DATA_W-1:0] tid_o,
  output logic [`CNT_W-1:0]      cnt_o,
  output logic                   timer_fire_o
);

  logic [`CSR_DATA_W-1:0] tcfg_q;
  logic [`CSR_DATA_W-1:0] tval_q;
  logic [`CSR_DATA_W-1:0] tid_q;
  logic [`CNT_W-1:0]      cnt_q;
  logic                   timer_en_q;
  logic [`CSR_DATA_W-1:0] reload_val;

  // initval counts in units of four cycles
  assign reload_val = {tcfg_q[`TCFG_INITVAL], 2'b00};

  assign timer_fire_o = timer_en_q && (tval_q == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_q     <= '0;
      tval_q     <= '0;
      timer_en_q <= 1'b0;
    end else if (tcfg_we_i) begin
      tcfg_q     <= w_data_i;
      tval_q     <= {w_data_i[`TCFG_INITVAL], 2'b00};
      timer_en_q <= w_data_i[`TCFG_EN];
    end else if (timer_en_q) begin
      if (tval_q != '0) begin
        tval_q <= tval_q - 1'b1;
      end else begin
        // one-shot parks at all ones and stops
        tval_q     <= tcfg_q[`TCFG_PERIODIC] ? reload_val : '1;
        timer_en_q <= tcfg_q[`TCFG_PERIODIC];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tid_we_i) begin
      tid_q <= w_data_i;
    end
  end

  assign tcfg_o = tcfg_q;
  assign tval_o = tval_q;
  assign tid_o  = tid_q;
  assign cnt_o  = cnt_q;

  a_tval_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (!timer_en_q && !tcfg_we_i) |=> $stable(tval_q)
  );

endmodule

/* verilog.f */
+incdir+common
+incdir+testbench
common/csr_pkg.sv
excp/excp_priority.sv
excp/excp_state.sv
timer/timer_unit.sv
logic/csr_access.sv
logic/csr_top.sv
testbench/tb_csr.sv
